// ==== common/isa_pkg.sv ====
package isa_pkg;

    // architectural widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // decoded slots offered by the front end each cycle
    localparam int NUM_SLOTS = 2;

    // data memory, word addressed through the low bits of the word index
    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_ADDI = 4'd6,
        OP_LD   = 4'd7,
        OP_ST   = 4'd8
    } op_t;

endpackage

// ==== common/pipe_pkg.sv ====
package pipe_pkg;

    import isa_pkg::*;

    // one decoded instruction as offered by the source
    typedef struct packed {
        logic                  valid;
        op_t                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;
    } id_slot_t;

    // issued instruction, operands already resolved
    // opb is the immediate for ADDI and LD, store data for ST
    typedef struct packed {
        logic                  valid;
        op_t                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       opa;
        logic [XLEN-1:0]       opb;
        logic [XLEN-1:0]       imm;
    } dispatch_ex_t;

    // forwarding source, also the register write record
    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } fwd_t;

    // execute result on its way to memory
    typedef struct packed {
        logic                  valid;
        op_t                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       sdata;
    } ex_mem_t;

endpackage

// ==== dispatch/dispatch.sv ====
`timescale 1ns/1ps

module dispatch
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       flush_i,

    // from the slot source
    input  id_slot_t [NUM_SLOTS-1:0]   slots_i,

    // register file
    output logic [1:0][REG_ADDR_W-1:0] rs_addr_o,
    input  logic [1:0][XLEN-1:0]       rs_data_i,

    // forwarding sources
    input  fwd_t                       ex_fwd_i,
    input  fwd_t                       mem_fwd_i,
    input  fwd_t                       wb_fwd_i,
    input  logic                       ex_is_load_i,

    output logic [NUM_SLOTS-1:0]       issue_o,
    output logic                       stall_o,
    output dispatch_ex_t               ex_o
);

    id_slot_t                         sel;
    logic [$clog2(NUM_SLOTS)-1:0]     sel_idx;
    logic                             any_valid;
    logic                             uses_rs1;
    logic                             uses_rs2;
    logic                             go;
    logic [XLEN-1:0]                  val_rs1;
    logic [XLEN-1:0]                  val_rs2;
    dispatch_ex_t                     ex_next;

    // newest producer wins, register 0 is hardwired
    function automatic logic [XLEN-1:0] resolve(input logic [REG_ADDR_W-1:0] addr,
                                                input logic [XLEN-1:0]       rf_data);
        logic [XLEN-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (ex_fwd_i.en && ex_fwd_i.addr == addr) begin
            val = ex_fwd_i.data;
        end else if (mem_fwd_i.en && mem_fwd_i.addr == addr) begin
            val = mem_fwd_i.data;
        end else if (wb_fwd_i.en && wb_fwd_i.addr == addr) begin
            val = wb_fwd_i.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    // oldest valid slot, slot 0 first
    always_comb begin
        sel_idx   = '0;
        any_valid = 1'b0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (slots_i[i].valid) begin
                sel_idx   = i[$clog2(NUM_SLOTS)-1:0];
                any_valid = 1'b1;
            end
        end
    end

    assign sel = slots_i[sel_idx];

    always_comb begin
        uses_rs1 = sel.valid && (sel.op != OP_NOP);
        case (sel.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ST: uses_rs2 = sel.valid;
            default:                                      uses_rs2 = 1'b0;
        endcase
    end

    assign rs_addr_o[0] = sel.rs1;
    assign rs_addr_o[1] = sel.rs2;

    // load in execute, its data shows up one cycle too late
    assign stall_o = ex_is_load_i &&
                     ((uses_rs1 && sel.rs1 == ex_fwd_i.addr) ||
                      (uses_rs2 && sel.rs2 == ex_fwd_i.addr));

    assign go = any_valid && !stall_o && !flush_i;

    always_comb begin
        issue_o = '0;
        if (go) begin
            issue_o[sel_idx] = 1'b1;
        end
    end

    always_comb begin
        val_rs1 = resolve(sel.rs1, rs_data_i[0]);
        val_rs2 = resolve(sel.rs2, rs_data_i[1]);
    end

    always_comb begin
        ex_next       = '0;
        ex_next.valid = 1'b1;
        ex_next.op    = sel.op;
        ex_next.rd    = sel.rd;
        ex_next.imm   = sel.imm;
        ex_next.opa   = uses_rs1 ? val_rs1 : '0;
        case (sel.op)
            OP_ADDI, OP_LD: ex_next.opb = sel.imm;
            OP_NOP:         ex_next.opb = '0;
            default:        ex_next.opb = val_rs2;
        endcase
    end

    // execute register, bubble on flush, stall or empty slots
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_o <= '0;
        end else if (go) begin
            ex_o <= ex_next;
        end else begin
            ex_o <= '0;
        end
    end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic [1:0][REG_ADDR_W-1:0] rs_addr_i,
    input  fwd_t                       wr_i,
    output logic [1:0][XLEN-1:0]       rs_data_o
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.en && wr_i.addr != '0) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // no internal bypass, dispatch forwards from writeback
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            rs_data_o[p] = regs[rs_addr_i[p]];
        end
    end

endmodule

// ==== logic/exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic         clk,
    input  logic         reset_i,
    input  logic         flush_i,
    input  dispatch_ex_t ex_i,
    output fwd_t         ex_fwd_o,
    output logic         ex_is_load_o,
    output ex_mem_t      mem_o
);

    logic [XLEN-1:0] result;
    logic            is_alu;

    always_comb begin
        is_alu = 1'b0;
        case (ex_i.op)
            OP_ADD: begin
                result = ex_i.opa + ex_i.opb;
                is_alu = 1'b1;
            end
            OP_SUB: begin
                result = ex_i.opa - ex_i.opb;
                is_alu = 1'b1;
            end
            OP_AND: begin
                result = ex_i.opa & ex_i.opb;
                is_alu = 1'b1;
            end
            OP_OR: begin
                result = ex_i.opa | ex_i.opb;
                is_alu = 1'b1;
            end
            OP_XOR: begin
                result = ex_i.opa ^ ex_i.opb;
                is_alu = 1'b1;
            end
            OP_ADDI: begin
                result = ex_i.opa + ex_i.opb;
                is_alu = 1'b1;
            end
            // address for loads and stores
            OP_LD, OP_ST: result = ex_i.opa + ex_i.imm;
            default:      result = '0;
        endcase
    end

    // address is published even for loads, dispatch uses it for the hazard
    assign ex_fwd_o.en   = ex_i.valid && is_alu && ex_i.rd != '0;
    assign ex_fwd_o.addr = ex_i.rd;
    assign ex_fwd_o.data = result;

    assign ex_is_load_o = ex_i.valid && ex_i.op == OP_LD && ex_i.rd != '0;

    // a flush drops the instruction now in execute
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_o.valid <= 1'b0;
        end else begin
            mem_o.valid  <= ex_i.valid && !flush_i;
            mem_o.op     <= ex_i.op;
            mem_o.rd     <= ex_i.rd;
            mem_o.result <= result;
            mem_o.sdata  <= ex_i.opb;
        end
    end

endmodule

// ==== logic/mem_wb_stage.sv ====
`timescale 1ns/1ps

module mem_wb_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    input  ex_mem_t mem_i,
    output fwd_t    mem_fwd_o,
    output fwd_t    wb_fwd_o
);

    logic [XLEN-1:0]        dmem [DMEM_WORDS];
    logic [DMEM_ADDR_W-1:0] widx;
    logic [XLEN-1:0]        rdata;
    logic                   writes_rd;
    fwd_t                   wb_q;

    // byte address, word index in the low bits
    assign widx  = mem_i.result[2 +: DMEM_ADDR_W];
    assign rdata = dmem[widx];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_i.valid && mem_i.op == OP_ST) begin
            dmem[widx] <= mem_i.sdata;
        end
    end

    always_comb begin
        case (mem_i.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LD: writes_rd = 1'b1;
            default:                                               writes_rd = 1'b0;
        endcase
    end

    // load data is ready here, so memory can forward it
    assign mem_fwd_o.en   = mem_i.valid && writes_rd && mem_i.rd != '0;
    assign mem_fwd_o.addr = mem_i.rd;
    assign mem_fwd_o.data = (mem_i.op == OP_LD) ? rdata : mem_i.result;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_q.en <= 1'b0;
        end else begin
            wb_q <= mem_fwd_o;
        end
    end

    assign wb_fwd_o = wb_q;

endmodule

// ==== logic/issue_core.sv ====
`timescale 1ns/1ps

module issue_core
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     flush_i,
    input  id_slot_t [NUM_SLOTS-1:0] slots_i,
    output logic [NUM_SLOTS-1:0]     issue_o,
    output logic                     stall_o,
    output fwd_t                     wb_o
);

    logic [1:0][REG_ADDR_W-1:0] rs_addr;
    logic [1:0][XLEN-1:0]       rs_data;
    dispatch_ex_t               ex_reg;
    ex_mem_t                    mem_reg;
    fwd_t                       ex_fwd;
    fwd_t                       mem_fwd;
    fwd_t                       wb_fwd;
    logic                       ex_is_load;

    dispatch u_dispatch (
        .clk          (clk),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .slots_i      (slots_i),
        .rs_addr_o    (rs_addr),
        .rs_data_i    (rs_data),
        .ex_fwd_i     (ex_fwd),
        .mem_fwd_i    (mem_fwd),
        .wb_fwd_i     (wb_fwd),
        .ex_is_load_i (ex_is_load),
        .issue_o      (issue_o),
        .stall_o      (stall_o),
        .ex_o         (ex_reg)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .reset_i   (reset_i),
        .rs_addr_i (rs_addr),
        .wr_i      (wb_fwd),
        .rs_data_o (rs_data)
    );

    exec_stage u_exec_stage (
        .clk          (clk),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .ex_i         (ex_reg),
        .ex_fwd_o     (ex_fwd),
        .ex_is_load_o (ex_is_load),
        .mem_o        (mem_reg)
    );

    mem_wb_stage u_mem_wb_stage (
        .clk       (clk),
        .reset_i   (reset_i),
        .mem_i     (mem_reg),
        .mem_fwd_o (mem_fwd),
        .wb_fwd_o  (wb_fwd)
    );

    assign wb_o = wb_fwd;

endmodule

// ==== tests/issue_core_sva.sv ====
`timescale 1ns/1ps

module issue_core_sva
    import isa_pkg::*, pipe_pkg::*;
(
    input logic                 clk,
    input logic                 reset_i,
    input logic                 flush_i,
    input logic [NUM_SLOTS-1:0] issue_o,
    input logic                 stall_o,
    input fwd_t                 wb_o
);

    // polled by the testbench
    int unsigned fail_count = 0;

    issue_onehot: assert property (@(posedge clk) disable iff (reset_i) $onehot0(issue_o))
        else begin
            fail_count++;
            $error("issue_o has more than one bit set");
        end

    no_issue_when_blocked: assert property (@(posedge clk) disable iff (reset_i)
        (stall_o || flush_i) |-> issue_o == '0)
        else begin
            fail_count++;
            $error("issue_o set during a stall or flush");
        end

    no_write_r0: assert property (@(posedge clk) disable iff (reset_i)
        wb_o.en |-> wb_o.addr != '0)
        else begin
            fail_count++;
            $error("wb_o writes register 0");
        end

    // first cycle out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset_i) |-> (issue_o == '0 && !stall_o && !wb_o.en))
        else begin
            fail_count++;
            $error("outputs active right after reset");
        end

endmodule

bind issue_core issue_core_sva u_sva (.*);

// ==== tests/issue_core_tb.sv ====
`timescale 1ns/1ps

module issue_core_tb
    import isa_pkg::*, pipe_pkg::*;
();

    localparam int PROG_LEN = 300;
    localparam int DIRECTED = 8;
    localparam int TIMEOUT  = 4000;

    logic                     clk = 1'b0;
    logic                     reset_i;
    logic                     flush_i;
    id_slot_t [NUM_SLOTS-1:0] slots_i;
    logic [NUM_SLOTS-1:0]     issue_o;
    logic                     stall_o;
    fwd_t                     wb_o;

    id_slot_t              prog [PROG_LEN];
    logic [XLEN-1:0]       model_regs [NUM_REGS] = '{default: '0};
    logic [XLEN-1:0]       model_mem [DMEM_WORDS] = '{default: '0};
    fwd_t                  exp_q [$];
    // issued at the last edge, still exposed to a flush
    id_slot_t              pend = '0;
    logic                  prev_ld = 1'b0;
    logic [REG_ADDR_W-1:0] prev_rd = '0;
    logic [15:0]           lfsr = 16'd3;
    int                    head;
    int                    waited;
    logic                  only_slot1;

    always #2 clk = ~clk;

    issue_core dut (
        .clk     (clk),
        .reset_i (reset_i),
        .flush_i (flush_i),
        .slots_i (slots_i),
        .issue_o (issue_o),
        .stall_o (stall_o),
        .wb_o    (wb_o)
    );

    task automatic fail_run();
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check(input string name, input logic [XLEN-1:0] got,
                         input logic [XLEN-1:0] want);
        if (got !== want) begin
            $display("error %s got %h expected %h", name, got, want);
            fail_run();
        end
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic put(input int i, input op_t op, input int rd, input int rs1,
                       input int rs2, input int imm);
        prog[i] = '{1'b1, op, rd[REG_ADDR_W-1:0], rs1[REG_ADDR_W-1:0],
                    rs2[REG_ADDR_W-1:0], imm};
    endtask

    // architectural model, returns the register write the instruction makes
    function automatic fwd_t ref_exec(input id_slot_t ins);
        fwd_t            w;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] addr;
        a      = model_regs[ins.rs1];
        b      = model_regs[ins.rs2];
        addr   = a + ins.imm;
        w.en   = !(ins.op inside {OP_NOP, OP_ST}) && ins.rd != '0;
        w.addr = ins.rd;
        case (ins.op)
            OP_ADD:  w.data = a + b;
            OP_SUB:  w.data = a - b;
            OP_AND:  w.data = a & b;
            OP_OR:   w.data = a | b;
            OP_XOR:  w.data = a ^ b;
            OP_ADDI: w.data = a + ins.imm;
            OP_LD:   w.data = model_mem[addr[2 +: DMEM_ADDR_W]];
            default: w.data = '0;
        endcase
        if (ins.op == OP_ST) begin
            model_mem[addr[2 +: DMEM_ADDR_W]] = b;
        end
        if (w.en) begin
            model_regs[ins.rd] = w.data;
        end
        return w;
    endfunction

    // slot selection, stall prediction and the reference model
    always @(posedge clk) begin
        id_slot_t             sel;
        logic                 exp_stall;
        logic [NUM_SLOTS-1:0] exp_issue;
        fwd_t                 w;
        if (!reset_i) begin
            sel       = slots_i[0].valid ? slots_i[0] : slots_i[1];
            exp_stall = prev_ld && sel.valid && sel.op != OP_NOP &&
                        (sel.rs1 == prev_rd ||
                         (!(sel.op inside {OP_ADDI, OP_LD}) && sel.rs2 == prev_rd));
            exp_issue = '0;
            if (sel.valid && !exp_stall && !flush_i) begin
                exp_issue = slots_i[0].valid ? 2'b01 : 2'b10;
            end
            check("stall_o", stall_o, exp_stall);
            check("issue_o", issue_o, exp_issue);
            if (pend.valid && !flush_i) begin
                w = ref_exec(pend);
                if (w.en) begin
                    exp_q.push_back(w);
                end
            end
            pend    = issue_o[0] ? slots_i[0] : (issue_o[1] ? slots_i[1] : '0);
            prev_ld = pend.valid && pend.op == OP_LD && pend.rd != '0;
            prev_rd = pend.rd;
        end
    end

    // writeback stream, in order
    always @(posedge clk) begin
        fwd_t want;
        if (!reset_i) begin
            if (dut.u_sva.fail_count != 0) begin
                $display("a bound assertion on issue_core failed");
                fail_run();
            end else if (wb_o.en && exp_q.size() == 0) begin
                $display("wb_o wrote register %0d with no write expected", wb_o.addr);
                fail_run();
            end else if (wb_o.en) begin
                want = exp_q.pop_front();
                check("wb_o.addr", wb_o.addr, want.addr);
                check("wb_o.data", wb_o.data, want.data);
            end
        end
    end

    initial begin
        reset_i = 1'b1;
        flush_i = 1'b0;
        slots_i = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i].valid = 1'b1;
            prog[i].op    = op_t'(4'(rand_bits(4) % 9));
            prog[i].rd    = REG_ADDR_W'(rand_bits(3));
            prog[i].rs1   = REG_ADDR_W'(rand_bits(3));
            prog[i].rs2   = REG_ADDR_W'(rand_bits(3));
            prog[i].imm   = rand_bits(8);
            // few word addresses, so loads often meet earlier stores
            if (prog[i].op inside {OP_LD, OP_ST}) begin
                prog[i].imm = prog[i].imm & 32'h1c;
                if (rand_bits(1) != 0) begin
                    prog[i].rs1 = '0;
                end
            end
        end
        // chain at distances 1 to 3, then store, load and a load-use
        put(0, OP_ADDI, 1, 0, 0, 5);
        put(1, OP_ADDI, 2, 1, 0, 3);
        put(2, OP_ADD,  3, 1, 2, 0);
        put(3, OP_XOR,  4, 1, 3, 0);
        put(4, OP_SUB,  5, 4, 2, 0);
        put(5, OP_ST,   0, 0, 5, 8);
        put(6, OP_LD,   6, 0, 0, 8);
        put(7, OP_ADD,  7, 6, 3, 0);

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_i    = 1'b0;
        head       = 0;
        only_slot1 = 1'b0;
        waited     = 0;
        while (head < PROG_LEN) begin
            @(negedge clk);
            flush_i    = head >= DIRECTED && rand_bits(8) < 6;
            slots_i[0] = only_slot1 ? '0 : prog[head];
            slots_i[1] = only_slot1 ? prog[head] :
                         ((head + 1 < PROG_LEN) ? prog[head + 1] : '0);
            @(posedge clk);
            if (issue_o != '0) begin
                head++;
                only_slot1 = head >= DIRECTED && rand_bits(3) == 0;
            end
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout, the program did not finish issuing");
                fail_run();
            end
        end

        @(negedge clk);
        flush_i = 1'b0;
        slots_i = '0;
        waited  = 0;
        while (pend.valid || exp_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > 20) begin
                $display("timeout, expected writes never appeared on wb_o");
                fail_run();
            end
        end
        // quiet tail, stray writes would show up here
        repeat (4) @(negedge clk);

        if (dut.u_sva.fail_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            fail_run();
        end
    end

endmodule

// ==== list.f ====
common/isa_pkg.sv
common/pipe_pkg.sv
dispatch/dispatch.sv
logic/reg_file.sv
logic/exec_stage.sv
logic/mem_wb_stage.sv
logic/issue_core.sv
tests/issue_core_sva.sv
tests/issue_core_tb.sv
